// File: logic/access_fsm.sv
`timescale 1ns/1ps

module access_fsm
    import neuron_pkg::*, access_pkg::*;
#(
    parameter int NUM_NODES = 4
) (
    input  logic          cpu_clk,
    input  logic          rst_n,
    input  logic [7:0]    node_select,
    input  reg_addr_t     addr,
    input  logic          write_en,
    input  logic          read_en,
    input  reg_data_t     write_data,
    input  reg_data_t     bank_rdata [NUM_NODES],
    output bank_req_t     bank_req [NUM_NODES],
    output reg_data_t     read_data,
    output logic          ready
);

    access_state_e state;
    access_op_e    op_q;
    access_op_e    start_op;

    logic [7:0]    node_q;
    reg_addr_t     addr_q;
    reg_data_t     wdata_q;

    logic          node_valid;
    reg_data_t     sel_rdata;

    // Write wins when both strobes are high
    always_comb begin
        if (write_en) begin
            start_op = OP_WRITE;
        end else if (read_en) begin
            start_op = OP_READ;
        end else begin
            start_op = OP_NONE;
        end
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            op_q  <= OP_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_op != OP_NONE) begin
                        state <= ST_ACCESS;
                        op_q  <= start_op;
                    end
                end
                ST_ACCESS: begin
                    state <= ST_DONE;
                end
                default: begin  // ST_DONE
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields follow the bus while idle, then hold
    always_ff @(posedge cpu_clk) begin
        if (state == ST_IDLE) begin
            node_q  <= node_select;
            addr_q  <= addr;
            wdata_q <= write_data;
        end
    end

    assign node_valid = (node_q < 8'(NUM_NODES));  // Out-of-range select hits no bank

    // Only the selected bank sees a live opcode
    for (genvar i = 0; i < NUM_NODES; i++) begin : g_req
        assign bank_req[i].op    = (state == ST_ACCESS && node_q == 8'(i)) ? op_q : OP_NONE;
        assign bank_req[i].addr  = addr_q;
        assign bank_req[i].wdata = wdata_q;
    end

    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < NUM_NODES; i++) begin
            if (node_q == 8'(i)) begin
                sel_rdata = bank_rdata[i];
            end
        end
    end

    assign ready     = (state == ST_DONE);
    assign read_data = (ready && op_q == OP_READ && node_valid) ? sel_rdata : '0;

endmodule

// File: logic/access_pkg.sv
package access_pkg;

    import neuron_pkg::*;

    // Bus operation carried to a bank
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } access_op_e;

    // External access sequencing
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,  // Request valid at the bank
        ST_DONE   = 2'd2   // Ready pulse, read data returned
    } access_state_e;

    // Request presented to one neuron bank
    typedef struct packed {
        access_op_e op;
        reg_addr_t  addr;
        reg_data_t  wdata;
    } bank_req_t;

endpackage

// File: logic/neuron_bank.sv
`timescale 1ns/1ps

module neuron_bank
    import neuron_pkg::*, access_pkg::*;
#(
    parameter int NUM_NEURONS = 4
) (
    input  logic      cpu_clk,
    input  logic      rst_n,
    input  logic      tick,
    input  bank_req_t req,
    output reg_data_t rdata,
    output logic      interrupt
);

    logic [4:0]             nrn_idx;
    field_e                 field;
    logic                   is_write;
    logic                   status_wr;

    logic [NUM_NEURONS-1:0] wr_en;
    logic [NUM_NEURONS-1:0] spikes;
    logic [NUM_NEURONS-1:0] status;
    logic [NUM_NEURONS-1:0] clr_mask;

    potential_t             potential [NUM_NEURONS];
    potential_t             threshold [NUM_NEURONS];
    potential_t             leak      [NUM_NEURONS];
    potential_t             stimulus  [NUM_NEURONS];
    count_t                 count     [NUM_NEURONS];

    reg_data_t              rd_word;

    assign nrn_idx   = req.addr[7:3];
    assign field     = field_e'(req.addr[2:0]);
    assign is_write  = (req.op == OP_WRITE);
    assign status_wr = is_write && (req.addr == STATUS_ADDR);

    for (genvar i = 0; i < NUM_NEURONS; i++) begin : g_neuron
        assign wr_en[i] = is_write && (nrn_idx == 5'(i));

        neuron_unit u_neuron (
            .cpu_clk     (cpu_clk),
            .rst_n       (rst_n),
            .tick        (tick),
            .wr_en       (wr_en[i]),
            .field       (field),
            .wdata       (req.wdata[15:0]),
            .potential   (potential[i]),
            .threshold   (threshold[i]),
            .leak        (leak[i]),
            .stimulus    (stimulus[i]),
            .spike_count (count[i]),
            .spike       (spikes[i])
        );
    end

    // Read mux, anything unmapped returns zero
    always_comb begin
        rd_word = '0;
        if (req.addr == STATUS_ADDR) begin
            rd_word[NUM_NEURONS-1:0] = status;
        end else begin
            for (int i = 0; i < NUM_NEURONS; i++) begin
                if (nrn_idx == 5'(i)) begin
                    case (field)
                        FIELD_POTENTIAL: rd_word[15:0] = potential[i];
                        FIELD_THRESHOLD: rd_word[15:0] = threshold[i];
                        FIELD_LEAK:      rd_word[15:0] = leak[i];
                        FIELD_STIMULUS:  rd_word[15:0] = stimulus[i];
                        FIELD_COUNT:     rd_word[15:0] = count[i];
                        default:         rd_word       = '0;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (req.op == OP_READ) begin
            rdata <= rd_word;  // Returned in the following cycle
        end
    end

    assign clr_mask = status_wr ? req.wdata[NUM_NEURONS-1:0] : '0;

    // A new spike outranks a clear in the same cycle
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status <= (status & ~clr_mask) | spikes;
        end
    end

    assign interrupt = |status;

endmodule

// File: logic/neuron_pkg.sv
package neuron_pkg;

    // Membrane potential; threshold, leak and stimulus share this width
    typedef logic [15:0] potential_t;

    // Spike counter, wraps on overflow
    typedef logic [15:0] count_t;

    // Bank register address: neuron index in [7:3], field in [2:0]
    typedef logic [7:0] reg_addr_t;

    // Bus data word
    typedef logic [31:0] reg_data_t;

    // Per-neuron register fields (addr mod 8)
    typedef enum logic [2:0] {
        FIELD_POTENTIAL = 3'd0,  // Read only
        FIELD_THRESHOLD = 3'd1,
        FIELD_LEAK      = 3'd2,
        FIELD_STIMULUS  = 3'd3,
        FIELD_COUNT     = 3'd4   // Read only
    } field_e;

    // Sticky spike status, write 1 to clear
    localparam reg_addr_t STATUS_ADDR = 8'h80;

    // Threshold value out of reset
    localparam potential_t THRESHOLD_RESET = 16'h0100;

endpackage

// File: logic/neuron_unit.sv
`timescale 1ns/1ps

module neuron_unit
    import neuron_pkg::*;
(
    input  logic       cpu_clk,
    input  logic       rst_n,
    input  logic       tick,
    input  logic       wr_en,
    input  field_e     field,
    input  potential_t wdata,
    output potential_t potential,
    output potential_t threshold,
    output potential_t leak,
    output potential_t stimulus,
    output count_t     spike_count,
    output logic       spike
);

    potential_t  leaked;
    logic [16:0] sum;
    potential_t  integrated;
    logic        fire;

    // Leak floored at zero
    assign leaked = (potential > leak) ? potential - leak : '0;

    // Integrate with saturation
    assign sum        = {1'b0, leaked} + {1'b0, stimulus};
    assign integrated = sum[16] ? 16'hFFFF : sum[15:0];
    assign fire       = (integrated >= threshold);

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            potential   <= '0;
            spike_count <= '0;
            spike       <= 1'b0;
        end else begin
            spike <= tick && fire;
            if (tick) begin
                if (fire) begin
                    potential   <= '0;
                    spike_count <= spike_count + 1'b1;
                end else begin
                    potential <= integrated;
                end
            end
        end
    end

    // Bus writes beat the tick on the writable fields
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            threshold <= THRESHOLD_RESET;
            leak      <= '0;
            stimulus  <= '0;
        end else begin
            if (wr_en && field == FIELD_THRESHOLD) begin
                threshold <= wdata;
            end
            if (wr_en && field == FIELD_LEAK) begin
                leak <= wdata;
            end
            if (wr_en && field == FIELD_STIMULUS) begin
                stimulus <= wdata;
            end else if (tick) begin
                stimulus <= '0;  // Consumed by this timestep
            end
        end
    end

endmodule

// File: logic/spike_array_top.sv
`timescale 1ns/1ps

module spike_array_top
    import neuron_pkg::*, access_pkg::*;
#(
    parameter int NUM_NODES   = 4,
    parameter int NUM_NEURONS = 4,   // At most 8 per bank
    parameter int TICK_PERIOD = 16
) (
    input  logic                 cpu_clk,
    input  logic                 rst_n,
    input  logic [7:0]           ext_node_select,
    input  logic [7:0]           ext_addr,
    input  logic                 ext_write_en,
    input  logic                 ext_read_en,
    input  logic [31:0]          ext_write_data,
    output logic [31:0]          ext_read_data,
    output logic                 ext_ready,
    output logic [NUM_NODES-1:0] node_interrupts
);

    bank_req_t bank_req   [NUM_NODES];
    reg_data_t bank_rdata [NUM_NODES];
    logic      tick;

    access_fsm #(
        .NUM_NODES (NUM_NODES)
    ) u_access (
        .cpu_clk     (cpu_clk),
        .rst_n       (rst_n),
        .node_select (ext_node_select),
        .addr        (ext_addr),
        .write_en    (ext_write_en),
        .read_en     (ext_read_en),
        .write_data  (ext_write_data),
        .bank_rdata  (bank_rdata),
        .bank_req    (bank_req),
        .read_data   (ext_read_data),
        .ready       (ext_ready)
    );

    tick_timer #(
        .TICK_PERIOD (TICK_PERIOD)
    ) u_timer (
        .cpu_clk (cpu_clk),
        .rst_n   (rst_n),
        .tick    (tick)
    );

    // One bank per node, all stepped by the shared tick
    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        neuron_bank #(
            .NUM_NEURONS (NUM_NEURONS)
        ) u_bank (
            .cpu_clk   (cpu_clk),
            .rst_n     (rst_n),
            .tick      (tick),
            .req       (bank_req[n]),
            .rdata     (bank_rdata[n]),
            .interrupt (node_interrupts[n])
        );
    end

endmodule

// File: logic/tick_timer.sv
`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_PERIOD = 16
) (
    input  logic cpu_clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (TICK_PERIOD > 1) ? $clog2(TICK_PERIOD) : 1;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(TICK_PERIOD - 1));

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            tick <= wrap;  // One-cycle pulse per period
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module spike_array_tb \
    -f spike_array.f \
    -o spike_array_sim

./obj_dir/spike_array_sim > "$LOG" 2>&1 || { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"

// File: spike_array.f
logic/neuron_pkg.sv
logic/access_pkg.sv
logic/access_fsm.sv
logic/tick_timer.sv
logic/neuron_unit.sv
logic/neuron_bank.sv
logic/spike_array_top.sv
testbench/spike_array_assert.sv
testbench/spike_array_tb.sv

// File: testbench/spike_array_assert.sv
`timescale 1ns/1ps

module spike_array_assert
    import access_pkg::*;
(
    input logic          cpu_clk,
    input logic          rst_n,
    input access_state_e state,
    input logic          write_en,
    input logic          read_en,
    input logic          ready
);

    // Accepted strobe, ready two edges later
    a_ready_latency: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        (state == ST_IDLE && (write_en || read_en)) |-> ##2 ready)
        else $error("ready did not follow an accepted strobe after two cycles");

    a_ready_single: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        ready |=> !ready)
        else $error("ready stayed high for two cycles in a row");

    a_ready_state: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        (state != ST_DONE) |-> !ready)
        else $error("ready high outside ST_DONE");

endmodule

bind access_fsm spike_array_assert u_bus_assert (
    .cpu_clk  (cpu_clk),
    .rst_n    (rst_n),
    .state    (state),
    .write_en (write_en),
    .read_en  (read_en),
    .ready    (ready)
);

// File: testbench/spike_array_tb.sv
`timescale 1ns/1ps

module spike_array_tb
    import neuron_pkg::*;
();

    localparam int NUM_NODES     = 4;
    localparam int READY_TIMEOUT = 10;   // Cycles per bus access
    localparam int POLL_LIMIT    = 200;  // Reads per poll step
    localparam int IRQ_TIMEOUT   = 200;  // Cycles per interrupt wait

    typedef enum logic [2:0] {
        DO_WRITE,
        DO_READ,
        DO_POLL,
        DO_WAIT_IRQ,
        DO_CHECK_IRQ
    } step_kind_e;

    typedef struct packed {
        step_kind_e  kind;
        logic [7:0]  node;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] expected;
    } step_t;

    logic                 cpu_clk;
    logic                 rst_n;
    logic [7:0]           ext_node_select;
    logic [7:0]           ext_addr;
    logic                 ext_write_en;
    logic                 ext_read_en;
    logic [31:0]          ext_write_data;
    logic [31:0]          ext_read_data;
    logic                 ext_ready;
    logic [NUM_NODES-1:0] node_interrupts;

    step_t steps [$];
    string step_names [$];
    int    mismatch_count;
    int    timeout_count;

    spike_array_top uut (
        .cpu_clk         (cpu_clk),
        .rst_n           (rst_n),
        .ext_node_select (ext_node_select),
        .ext_addr        (ext_addr),
        .ext_write_en    (ext_write_en),
        .ext_read_en     (ext_read_en),
        .ext_write_data  (ext_write_data),
        .ext_read_data   (ext_read_data),
        .ext_ready       (ext_ready),
        .node_interrupts (node_interrupts)
    );

    always #2 cpu_clk = ~cpu_clk;

    // Neuron index times 8 plus field
    function automatic logic [7:0] reg_addr(int neuron, field_e field);
        return 8'(neuron * 8 + int'(field));
    endfunction

    function automatic void add_step(string name, step_kind_e kind, int node,
                                     logic [7:0] addr, logic [31:0] wdata,
                                     logic [31:0] expected);
        step_t s;
        s.kind     = kind;
        s.node     = 8'(node);
        s.addr     = addr;
        s.wdata    = wdata;
        s.expected = expected;
        steps.push_back(s);
        step_names.push_back(name);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // One strobe, then wait for the ready pulse and step back to idle
    task automatic bus_access(input logic is_write, input logic [7:0] node,
                              input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic done);
        int cycles;
        cycles          = 0;
        rdata           = '0;
        done            = 1'b0;
        ext_node_select = node;
        ext_addr        = addr;
        ext_write_data  = wdata;
        ext_write_en    = is_write;
        ext_read_en     = !is_write;
        @(posedge cpu_clk);
        #1;
        ext_write_en = 1'b0;
        ext_read_en  = 1'b0;
        while (!ext_ready && cycles < READY_TIMEOUT) begin
            @(posedge cpu_clk);
            #1;
            cycles++;
        end
        if (ext_ready) begin
            done  = 1'b1;
            rdata = ext_read_data;
        end else begin
            $display("Bus access to node %0d address 0x%02h got no ready within %0d cycles",
                     node, addr, READY_TIMEOUT);
            timeout_count++;
        end
        @(posedge cpu_clk);  // FSM back in idle
        #1;
    endtask

    task automatic run_step(int idx);
        step_t                s;
        string                name;
        logic [31:0]          rdata;
        logic                 done;
        logic                 matched;
        int                   tries;
        logic [NUM_NODES-1:0] irq_mask;
        s        = steps[idx];
        name     = step_names[idx];
        tries    = 0;
        matched  = 1'b0;
        irq_mask = {{(NUM_NODES-1){1'b0}}, 1'b1} << s.node;
        case (s.kind)
            DO_WRITE: begin
                bus_access(1'b1, s.node, s.addr, s.wdata, rdata, done);
                if (done) begin
                    check_value(name, s.expected, rdata);  // Write returns zero data
                end
            end
            DO_READ: begin
                bus_access(1'b0, s.node, s.addr, s.wdata, rdata, done);
                if (done) begin
                    check_value(name, s.expected, rdata);
                end
            end
            DO_POLL: begin
                while (!matched && tries < POLL_LIMIT) begin
                    bus_access(1'b0, s.node, s.addr, s.wdata, rdata, done);
                    matched = done && (rdata == s.expected);
                    tries++;
                end
                if (!matched) begin
                    $display("Step %s: register never read 0x%08h within %0d reads",
                             name, s.expected, POLL_LIMIT);
                    timeout_count++;
                end
            end
            DO_WAIT_IRQ: begin
                while ((node_interrupts & irq_mask) == '0 && tries < IRQ_TIMEOUT) begin
                    @(posedge cpu_clk);
                    #1;
                    tries++;
                end
                if ((node_interrupts & irq_mask) == '0) begin
                    $display("Step %s: interrupt of node %0d never rose within %0d cycles",
                             name, s.node, IRQ_TIMEOUT);
                    timeout_count++;
                end
            end
            default: begin
                check_value(name, s.expected, 32'(node_interrupts));
            end
        endcase
    endtask

    task automatic build_table();
        for (int n = 0; n < NUM_NODES; n++) begin
            add_step($sformatf("reset_thr_n%0d", n), DO_READ, n,
                     reg_addr(0, FIELD_THRESHOLD), 32'd0, 32'(THRESHOLD_RESET));
            add_step($sformatf("reset_cnt_n%0d", n), DO_READ, n,
                     reg_addr(0, FIELD_COUNT), 32'd0, 32'd0);
        end
        // Distinct values per node on neuron 1
        for (int n = 0; n < NUM_NODES; n++) begin
            add_step("iso_wr_thr", DO_WRITE, n, reg_addr(1, FIELD_THRESHOLD),
                     32'h200 + 32'(n), 32'd0);
            add_step("iso_wr_leak", DO_WRITE, n, reg_addr(1, FIELD_LEAK),
                     32'h10 + 32'(n), 32'd0);
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            add_step($sformatf("iso_thr_n%0d", n), DO_READ, n, reg_addr(1, FIELD_THRESHOLD),
                     32'd0, 32'h200 + 32'(n));
            add_step($sformatf("iso_leak_n%0d", n), DO_READ, n, reg_addr(1, FIELD_LEAK),
                     32'd0, 32'h10 + 32'(n));
        end
        add_step("unmapped_field", DO_READ, 3, 8'h0D, 32'd0, 32'd0);
        add_step("unmapped_neuron", DO_READ, 0, 8'h40, 32'd0, 32'd0);
        add_step("unmapped_high", DO_READ, 1, 8'h81, 32'd0, 32'd0);
        // Node 2 neuron 0 integrates below threshold
        add_step("sub_wr_leak", DO_WRITE, 2, reg_addr(0, FIELD_LEAK), 32'd0, 32'd0);
        add_step("sub_wr_thr", DO_WRITE, 2, reg_addr(0, FIELD_THRESHOLD), 32'd100, 32'd0);
        add_step("sub_wr_stim", DO_WRITE, 2, reg_addr(0, FIELD_STIMULUS), 32'd60, 32'd0);
        add_step("sub_stim_used", DO_POLL, 2, reg_addr(0, FIELD_STIMULUS), 32'd0, 32'd0);
        add_step("sub_potential", DO_READ, 2, reg_addr(0, FIELD_POTENTIAL), 32'd0, 32'd60);
        add_step("sub_count", DO_READ, 2, reg_addr(0, FIELD_COUNT), 32'd0, 32'd0);
        add_step("sub_irq", DO_CHECK_IRQ, 0, 8'h00, 32'd0, 32'd0);
        // 60 + 50 crosses 100
        add_step("fire_wr_stim", DO_WRITE, 2, reg_addr(0, FIELD_STIMULUS), 32'd50, 32'd0);
        add_step("fire_wait_irq", DO_WAIT_IRQ, 2, 8'h00, 32'd0, 32'd0);
        add_step("fire_count", DO_READ, 2, reg_addr(0, FIELD_COUNT), 32'd0, 32'd1);
        add_step("fire_potential", DO_READ, 2, reg_addr(0, FIELD_POTENTIAL), 32'd0, 32'd0);
        add_step("fire_status", DO_READ, 2, STATUS_ADDR, 32'd0, 32'd1);
        add_step("fire_irq", DO_CHECK_IRQ, 0, 8'h00, 32'd0, 32'h4);
        add_step("clr_status", DO_WRITE, 2, STATUS_ADDR, 32'd1, 32'd0);
        add_step("clr_irq", DO_CHECK_IRQ, 0, 8'h00, 32'd0, 32'd0);
        add_step("bad_node_wr", DO_WRITE, NUM_NODES, reg_addr(0, FIELD_THRESHOLD),
                 32'h1234, 32'd0);
        add_step("bad_node_rd", DO_READ, NUM_NODES, reg_addr(0, FIELD_THRESHOLD),
                 32'd0, 32'd0);
        for (int n = 0; n < NUM_NODES; n++) begin
            add_step($sformatf("bad_node_keep_n%0d", n), DO_READ, n,
                     reg_addr(0, FIELD_THRESHOLD), 32'd0,
                     (n == 2) ? 32'd100 : 32'(THRESHOLD_RESET));
        end
        // Node 1 neuron 2 decays to rest
        add_step("leak_wr_leak", DO_WRITE, 1, reg_addr(2, FIELD_LEAK), 32'd10, 32'd0);
        add_step("leak_wr_thr", DO_WRITE, 1, reg_addr(2, FIELD_THRESHOLD), 32'd1000, 32'd0);
        add_step("leak_wr_stim", DO_WRITE, 1, reg_addr(2, FIELD_STIMULUS), 32'd95, 32'd0);
        add_step("leak_stim_used", DO_POLL, 1, reg_addr(2, FIELD_STIMULUS), 32'd0, 32'd0);
        add_step("leak_to_zero", DO_POLL, 1, reg_addr(2, FIELD_POTENTIAL), 32'd0, 32'd0);
        add_step("leak_count", DO_READ, 1, reg_addr(2, FIELD_COUNT), 32'd0, 32'd0);
        add_step("leak_irq", DO_CHECK_IRQ, 0, 8'h00, 32'd0, 32'd0);
    endtask

    initial begin
        int idx;
        cpu_clk         = 1'b0;
        rst_n           = 1'b0;
        ext_node_select = '0;
        ext_addr        = '0;
        ext_write_en    = 1'b0;
        ext_read_en     = 1'b0;
        ext_write_data  = '0;
        mismatch_count  = 0;
        timeout_count   = 0;
        build_table();
        repeat (2) @(posedge cpu_clk);
        #1;
        rst_n = 1'b1;
        check_value("reset_irq", 32'd0, 32'(node_interrupts));
        for (idx = 0; idx < steps.size(); idx++) begin
            run_step(idx);
        end
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
